//--- bench/cacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTb import cachePkg::*; ();

  localparam int memLatency     = 4;                       // handed to the DUT
  localparam int periodNs       = 20;
  localparam int resetCycles    = 16;
  localparam int settleNs       = 1;                       // sample point after a falling edge
  localparam int idleCycles     = 20;                      // quiet cycles checked after reset
  localparam int accessBound    = 8*(memLatency+1) + 10;   // worst refill plus slack
  localparam int numRandom      = 300;
  localparam int numAccesses    = 1 + 9 + 8 + 18 + numRandom;
  localparam int watchdogCycles = resetCycles + idleCycles + numAccesses*accessBound;

  logic             clk;
  logic             rstN;
  logic [addrW-1:0] cpuAddr;
  logic [wordW-1:0] cpuWrData;
  logic             cpuRd;
  logic             cpuWr;
  logic [wordW-1:0] cpuRdData;
  logic             cpuStall;

  logic [wordW-1:0] shadow [memWords];  // what memory has to hold
  integer           seed;

  clockGen #(
    .periodNs   (periodNs),
    .resetCycles(resetCycles)
  ) clockGen_i (
    .clk (clk),
    .rstN(rstN)
  );

  cacheTop #(
    .memLatency(memLatency)
  ) cacheTop_i (
    .clk      (clk),
    .rstN     (rstN),
    .cpuAddr  (cpuAddr),
    .cpuWrData(cpuWrData),
    .cpuRd    (cpuRd),
    .cpuWr    (cpuWr),
    .cpuRdData(cpuRdData),
    .cpuStall (cpuStall)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  // tag, set and word offset packed into a byte address
  function automatic logic [addrW-1:0] buildAddr(input int tagNum, input int setNum,
                                                 input int offNum);
    return {tagNum[tagW-1:0], setNum[setW-1:0], offNum[offW-1:0], 1'b0};
  endfunction

  // entered and left just after a falling edge
  task automatic accessCache(input logic isWrite, input logic [addrW-1:0] addr,
                             input logic [wordW-1:0] data);
    int               waited;
    logic [wordW-1:0] expected;
    waited    = 0;
    expected  = shadow[addr[addrW-1:1]];
    cpuAddr   = addr;
    cpuWrData = data;
    cpuRd     = ~isWrite;
    cpuWr     = isWrite;
    #(settleNs);
    while (cpuStall) begin             // cpu holds the request
      waited++;
      assert (waited <= accessBound)
        else reportFailure($sformatf("cpuStall stuck high for cpuAddr %h", addr));
      @(negedge clk);
      #(settleNs);
    end
    if (!isWrite) begin
      assert (cpuRdData === expected)
        else reportFailure($sformatf("Mismatch cpuRdData: got %h expected %h at cpuAddr %h",
                                     cpuRdData, expected, addr));
    end
    @(posedge clk);                    // access completes here
    if (isWrite) begin
      shadow[addr[addrW-1:1]] = data;  // write-through keeps memory equal
    end
    @(negedge clk);
    cpuRd = 1'b0;
    cpuWr = 1'b0;
  endtask

  task automatic readWord(input logic [addrW-1:0] addr);
    accessCache(1'b0, addr, '0);
  endtask

  task automatic writeWord(input logic [addrW-1:0] addr, input logic [wordW-1:0] data);
    accessCache(1'b1, addr, data);
  endtask

  task automatic checkIdle(input int cycles);
    repeat (cycles) begin
      #(settleNs);
      assert (cpuStall === 1'b0)
        else reportFailure($sformatf("Mismatch cpuStall: got %h expected %h with no request",
                                     cpuStall, 1'b0));
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int               r;
    logic [addrW-1:0] addr;
    cpuAddr   = '0;
    cpuWrData = '0;
    cpuRd     = 1'b0;
    cpuWr     = 1'b0;
    seed      = 32'ha0a9f375;
    for (int i = 0; i < memWords; i++) begin
      shadow[i] = '0;                  // memory comes up cleared
    end
    wait (rstN === 1'b1);
    @(negedge clk);

    checkIdle(idleCycles);             // stall stays low without a request
    readWord(buildAddr(3, 5, 2));      // cold miss returns zero

    writeWord(buildAddr(1, 2, 3), 16'hbeef);   // allocate on write miss
    for (int off = 0; off < wordsPerBlock; off++) begin
      readWord(buildAddr(1, 2, off));
    end

    for (int k = 0; k < 4; k++) begin  // write hits then read back
      writeWord(buildAddr(1, 2, 2*k), 16'h1000 + k);
      readWord(buildAddr(1, 2, 2*k));
    end

    // three tags fighting over two ways of set 9
    for (int i = 0; i < 3; i++) begin
      writeWord(buildAddr(10*(i+1), 9, i), 16'ha000 + i);
    end
    for (int round = 0; round < 3; round++) begin
      for (int i = 0; i < 3; i++) begin
        readWord(buildAddr(10*(i+1), 9, i));   // each one evicts
      end
    end
    for (int i = 0; i < 3; i++) begin
      writeWord(buildAddr(10*(i+1), 9, i+4), 16'hb000 + i);
    end
    for (int i = 0; i < 3; i++) begin
      readWord(buildAddr(10*(i+1), 9, i+4));
    end

    repeat (numRandom) begin           // four tags over four sets
      r    = $random(seed);
      addr = buildAddr(7 + 14*r[1:0], 17*r[3:2], r[6:4]);
      if (r[7]) begin
        writeWord(addr, r[31:16]);
      end else begin
        readWord(addr);
      end
    end

    $display("Done: no errors");
    $finish;
  end

  // whole run bounded by the worst case per access
  initial begin
    repeat (watchdogCycles) @(posedge clk);
    reportFailure($sformatf("Timeout after %0d cycles", watchdogCycles));
  end

endmodule

`default_nettype wire

//--- bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int periodNs    = 20,      // clock period
  parameter int resetCycles = 16       // rising edges seen with rstN low
) (
  output logic clk,                    // free running clock
  output logic rstN                    // sync reset, active low
);

  initial begin
    clk = 1'b0;
    forever #(periodNs/2) clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;                       // released on a falling edge
  end

endmodule

`default_nettype wire

//--- common/cachePkg.sv
`default_nettype none

package cachePkg;

  ////////////////////////////////////////////////////////////////////////////
  // cpu word and address
  ////////////////////////////////////////////////////////////////////////////

  localparam int addrW = 16;          // cpu byte address
  localparam int wordW = 16;          // data word

  // address split, bit 0 is the byte select and is ignored
  localparam int tagW   = 6;          // bits 15 to 10
  localparam int setW   = 6;          // bits 9 to 4
  localparam int offW   = 3;          // bits 3 to 1
  localparam int tagLsb = 10;         // low bit of the tag field
  localparam int setLsb = 4;          // low bit of the set field
  localparam int offLsb = 1;          // low bit of the word offset

  ////////////////////////////////////////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int numSets       = 64;  // sets per way
  localparam int wordsPerBlock = 8;   // words per block

  // one metadata byte per set and way
  // tag sits in the low bits with valid and lru above it
  localparam int metaW        = 8;
  localparam int metaValidBit = 6;    // block holds live data
  localparam int metaLruBit   = 7;    // set when this way was used last

  ////////////////////////////////////////////////////////////////////////////
  // backing store
  ////////////////////////////////////////////////////////////////////////////

  localparam int memWords = 32768;    // word addressed by cpu bits 15 to 1

endpackage

`default_nettype wire

//--- dataCache/dataArray.sv
`timescale 1ns/1ps
`default_nettype none

module dataArray import cachePkg::*; (
  input  logic             clk,        // core clock
  input  logic             rstN,       // sync reset, active low
  input  logic [setW-1:0]  setIdx,     // block select
  input  logic [offW-1:0]  wordIdx,    // word inside the block
  input  logic             we,         // word write enable
  input  logic [wordW-1:0] wrData,     // word to store
  output logic [wordW-1:0] rdData      // word at setIdx/wordIdx
);

  // flat storage for one way
  logic [wordW-1:0] words [numSets*wordsPerBlock];

  logic [setW+offW-1:0] wordAddr;      // set and offset joined

  assign wordAddr = {setIdx, wordIdx};

  always_ff @(posedge clk) begin
    if (we && rstN) begin              // held off while in reset
      words[wordAddr] <= wrData;
    end
  end

  assign rdData = words[wordAddr];     // async read for the hit path

endmodule

`default_nettype wire

//--- dataCache/dataCache.sv
`timescale 1ns/1ps
`default_nettype none

module dataCache import cachePkg::*; (
  input  logic             clk,          // core clock
  input  logic             rstN,         // sync reset, active low
  input  logic [addrW-1:0] cpuAddr,      // cpu byte address
  input  logic [wordW-1:0] cpuWrData,    // cpu word for a write hit
  input  logic             cpuRd,        // read request level
  input  logic             cpuWr,        // write request level
  output logic [wordW-1:0] cpuRdData,    // word returned to the cpu
  input  logic [addrW-1:0] fillAddr,     // refill word address
  input  logic [wordW-1:0] fillData,     // refill word from memory
  input  logic             fillDataWe,   // one strobe per refill word
  input  logic             fillMetaWe,   // refill done so install the new tag
  output logic             miss,         // request found in neither way
  output logic             stall         // registered metadata being written
);

  ////////////////////////////////////////////////////////////////////////////
  // address fields
  ////////////////////////////////////////////////////////////////////////////

  logic [tagW-1:0]  cpuTag;
  logic [setW-1:0]  cpuSet;
  logic [offW-1:0]  cpuOff;
  logic [tagW-1:0]  fillTag;
  logic [offW-1:0]  fillOff;

  assign cpuTag  = cpuAddr[tagLsb +: tagW];
  assign cpuSet  = cpuAddr[setLsb +: setW];
  assign cpuOff  = cpuAddr[offLsb +: offW];
  assign fillTag = fillAddr[tagLsb +: tagW];
  assign fillOff = fillAddr[offLsb +: offW];

  // metadata side
  logic [metaW-1:0] leftMetaRd;          // stored byte, left way
  logic [metaW-1:0] rightMetaRd;         // stored byte, right way
  logic [metaW-1:0] leftMetaNew;         // next byte, left way
  logic [metaW-1:0] rightMetaNew;        // next byte, right way
  logic [metaW-1:0] leftMetaReg;         // byte waiting to be written
  logic [metaW-1:0] rightMetaReg;
  logic [setW-1:0]  setStalled;          // set of the waiting write
  logic [setW-1:0]  leftMetaSet;
  logic [setW-1:0]  rightMetaSet;
  logic             leftPend;            // left write in flight
  logic             rightPend;           // right write in flight
  logic             leftUpd;
  logic             rightUpd;

  // lookup
  logic             req;
  logic             leftHit;
  logic             rightHit;
  logic             anyHit;
  logic             goLeft;              // victim way on a refill
  logic             usedLeft;            // way that becomes most recent
  logic [tagW-1:0]  newTag;

  // data side
  logic [offW-1:0]  dataOff;
  logic [wordW-1:0] dataWrWord;
  logic             leftDataWe;
  logic             rightDataWe;
  logic [wordW-1:0] leftRdData;
  logic [wordW-1:0] rightRdData;

  ////////////////////////////////////////////////////////////////////////////
  // way storage
  ////////////////////////////////////////////////////////////////////////////

  dataArray leftData (
    .clk    (clk),
    .rstN   (rstN),
    .setIdx (cpuSet),
    .wordIdx(dataOff),
    .we     (leftDataWe),
    .wrData (dataWrWord),
    .rdData (leftRdData)
  );

  dataArray rightData (
    .clk    (clk),
    .rstN   (rstN),
    .setIdx (cpuSet),
    .wordIdx(dataOff),
    .we     (rightDataWe),
    .wrData (dataWrWord),
    .rdData (rightRdData)
  );

  // a way with a write in flight is indexed by the stalled set
  assign leftMetaSet  = leftPend  ? setStalled : cpuSet;
  assign rightMetaSet = rightPend ? setStalled : cpuSet;

  metaArray leftMeta (
    .clk   (clk),
    .rstN  (rstN),
    .setIdx(leftMetaSet),
    .we    (leftPend),
    .wrMeta(leftMetaReg),
    .rdMeta(leftMetaRd)
  );

  metaArray rightMeta (
    .clk   (clk),
    .rstN  (rstN),
    .setIdx(rightMetaSet),
    .we    (rightPend),
    .wrMeta(rightMetaReg),
    .rdMeta(rightMetaRd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // hit and miss
  ////////////////////////////////////////////////////////////////////////////

  assign req      = cpuRd | cpuWr;
  assign leftHit  = ~leftPend  & leftMetaRd[metaValidBit]  & (leftMetaRd[tagW-1:0]  == cpuTag);
  assign rightHit = ~rightPend & rightMetaRd[metaValidBit] & (rightMetaRd[tagW-1:0] == cpuTag);
  assign anyHit   = req & (leftHit | rightHit);
  assign miss     = req & ~(leftHit | rightHit);   // level seen by the miss handler
  assign goLeft   = ~leftMetaRd[metaLruBit];       // left not used last so it goes

  assign cpuRdData = leftHit ? leftRdData : rightRdData;

  // fill words win over cpu words
  assign dataOff     = fillDataWe ? fillOff : cpuOff;
  assign dataWrWord  = fillDataWe ? fillData : cpuWrData;
  assign leftDataWe  = fillDataWe ? goLeft  : (cpuWr & leftHit  & ~stall);
  assign rightDataWe = fillDataWe ? ~goLeft : (cpuWr & rightHit & ~stall);

  ////////////////////////////////////////////////////////////////////////////
  // lru and tag update
  ////////////////////////////////////////////////////////////////////////////

  assign usedLeft = fillMetaWe ? goLeft : leftHit;
  assign newTag   = fillMetaWe ? fillTag : cpuTag;

  always_comb begin
    leftMetaNew              = leftMetaRd;
    rightMetaNew             = rightMetaRd;
    leftMetaNew[metaLruBit]  = usedLeft;         // used way marked recent
    rightMetaNew[metaLruBit] = ~usedLeft;        // other way cleared
    if (usedLeft) begin
      leftMetaNew[tagW-1:0]      = newTag;
      leftMetaNew[metaValidBit]  = 1'b1;
    end else begin
      rightMetaNew[tagW-1:0]     = newTag;
      rightMetaNew[metaValidBit] = 1'b1;
    end
  end

  // only bytes that really change get written
  assign leftUpd  = (anyHit | fillMetaWe) & ~stall & (leftMetaNew  != leftMetaRd);
  assign rightUpd = (anyHit | fillMetaWe) & ~stall & (rightMetaNew != rightMetaRd);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      leftPend  <= 1'b0;
      rightPend <= 1'b0;
    end else begin
      leftPend  <= leftUpd;                      // lasts one cycle
      rightPend <= rightUpd;
    end
  end

  always_ff @(posedge clk) begin
    leftMetaReg  <= leftMetaNew;
    rightMetaReg <= rightMetaNew;
    setStalled   <= cpuSet;
  end

  assign stall = leftPend | rightPend;           // cycle of the metadata write

endmodule

`default_nettype wire

//--- dataCache/metaArray.sv
`timescale 1ns/1ps
`default_nettype none

module metaArray import cachePkg::*; (
  input  logic             clk,        // core clock
  input  logic             rstN,       // sync reset, active low
  input  logic [setW-1:0]  setIdx,     // read and write index
  input  logic             we,         // metadata write enable
  input  logic [metaW-1:0] wrMeta,     // new tag/valid/lru
  output logic [metaW-1:0] rdMeta      // stored tag/valid/lru
);

  logic [metaW-1:0] meta [numSets];    // one byte per set

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < numSets; i++) begin
        meta[i] <= '0;                 // invalid with lru clear
      end
    end else if (we) begin
      meta[setIdx] <= wrMeta;
    end
  end

  assign rdMeta = meta[setIdx];        // async read for tag compare

endmodule

`default_nettype wire

//--- hdl/cacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTop import cachePkg::*; #(
  parameter int memLatency = 4           // memory read latency in cycles
) (
  input  logic             clk,          // core clock
  input  logic             rstN,         // sync reset, active low
  input  logic [addrW-1:0] cpuAddr,      // cpu byte address
  input  logic [wordW-1:0] cpuWrData,    // cpu write word
  input  logic             cpuRd,        // read request level
  input  logic             cpuWr,        // write request level
  output logic [wordW-1:0] cpuRdData,    // read word
  output logic             cpuStall      // cpu holds its request while high
);

  // cache to miss handler
  logic             miss;
  logic             stall;
  logic [addrW-1:0] fillAddr;
  logic [wordW-1:0] fillData;
  logic             fillDataWe;
  logic             fillMetaWe;

  // miss handler to memory
  logic [addrW-2:0] memAddr;
  logic             memRd;
  logic             memWr;
  logic [wordW-1:0] memWrData;
  logic [wordW-1:0] memRdData;
  logic             memRdValid;

  dataCache dataCache_i (
    .clk       (clk),
    .rstN      (rstN),
    .cpuAddr   (cpuAddr),
    .cpuWrData (cpuWrData),
    .cpuRd     (cpuRd),
    .cpuWr     (cpuWr),
    .cpuRdData (cpuRdData),
    .fillAddr  (fillAddr),
    .fillData  (fillData),
    .fillDataWe(fillDataWe),
    .fillMetaWe(fillMetaWe),
    .miss      (miss),
    .stall     (stall)
  );

  missHandler missHandler_i (
    .clk       (clk),
    .rstN      (rstN),
    .cpuAddr   (cpuAddr),
    .cpuWrData (cpuWrData),
    .cpuWr     (cpuWr),
    .miss      (miss),
    .stall     (stall),
    .fillAddr  (fillAddr),
    .fillData  (fillData),
    .fillDataWe(fillDataWe),
    .fillMetaWe(fillMetaWe),
    .memAddr   (memAddr),
    .memRd     (memRd),
    .memWr     (memWr),
    .memWrData (memWrData),
    .memRdValid(memRdValid),
    .memRdData (memRdData)
  );

  mainMemory #(
    .memLatency(memLatency)
  ) mainMemory_i (
    .clk       (clk),
    .memAddr   (memAddr),
    .memRd     (memRd),
    .memWr     (memWr),
    .memWrData (memWrData),
    .memRdData (memRdData),
    .memRdValid(memRdValid)
  );

  assign cpuStall = miss | stall;        // refill or metadata write

endmodule

`default_nettype wire

//--- hdl/mainMemory.sv
`timescale 1ns/1ps
`default_nettype none

module mainMemory import cachePkg::*; #(
  parameter int memLatency = 4           // cycles from memRd to memRdValid
) (
  input  logic             clk,          // core clock
  input  logic [addrW-2:0] memAddr,      // word address
  input  logic             memRd,        // read strobe
  input  logic             memWr,        // write strobe
  input  logic [wordW-1:0] memWrData,    // word to write
  output logic [wordW-1:0] memRdData,    // word leaving the delay line
  output logic             memRdValid    // read data strobe
);

  logic [wordW-1:0]      mem [memWords];
  logic [memLatency-1:0] rdPipe = '0;    // read strobe delay line
  logic [addrW-2:0]      addrPipe [memLatency];

  initial begin
    for (int i = 0; i < memWords; i++) begin
      mem[i] = '0;                       // memory starts out cleared
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (memWr) begin
      mem[memAddr] <= memWrData;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read latency
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    rdPipe[0]   <= memRd;
    addrPipe[0] <= memAddr;
    for (int i = 1; i < memLatency; i++) begin
      rdPipe[i]   <= rdPipe[i-1];        // strobe and address move together
      addrPipe[i] <= addrPipe[i-1];
    end
  end

  assign memRdValid = rdPipe[memLatency-1];
  assign memRdData  = mem[addrPipe[memLatency-1]];   // looked up on the way out

endmodule

`default_nettype wire

//--- hdl/missHandler.sv
`timescale 1ns/1ps
`default_nettype none

module missHandler import cachePkg::*; (
  input  logic             clk,          // core clock
  input  logic             rstN,         // sync reset, active low
  input  logic [addrW-1:0] cpuAddr,      // held cpu address
  input  logic [wordW-1:0] cpuWrData,    // held cpu write word
  input  logic             cpuWr,        // write request level
  input  logic             miss,         // lookup missed
  input  logic             stall,        // cache busy with metadata
  output logic [addrW-1:0] fillAddr,     // address of the word being filled
  output logic [wordW-1:0] fillData,     // word being filled
  output logic             fillDataWe,   // fill word strobe
  output logic             fillMetaWe,   // tag install strobe
  output logic [addrW-2:0] memAddr,      // memory word address
  output logic             memRd,        // read strobe
  output logic             memWr,        // write-through strobe
  output logic [wordW-1:0] memWrData,    // write-through word
  input  logic             memRdValid,   // read data strobe
  input  logic [wordW-1:0] memRdData     // read data
);

  typedef enum logic [2:0] {
    idle,                                // serve write-through and watch for misses
    request,                             // issue one word read
    waitData,                            // wait out the memory latency
    writeMeta,                           // install tag and lru
    settle                               // cache writes the registered metadata
  } fillState;

  fillState                 state;
  logic [offW-1:0]          wordCnt;     // offset of the word in flight
  logic [addrW-offW-2:0]    blockBase;   // tag and set of the missing block
  logic                     startFill;
  logic                     writeHit;

  assign startFill = (state == idle) & miss & ~stall;
  assign writeHit  = (state == idle) & cpuWr & ~miss & ~stall;   // access completes now

  ////////////////////////////////////////////////////////////////////////////
  // refill sequence
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= idle;
      wordCnt <= '0;
    end else begin
      case (state)
        idle: begin
          if (startFill) begin
            wordCnt <= '0;               // always from offset 0
            state   <= request;
          end
        end
        request:   state <= waitData;
        waitData: begin
          if (memRdValid) begin
            wordCnt <= wordCnt + 1'b1;
            state   <= (wordCnt == '1) ? writeMeta : request;
          end
        end
        writeMeta: state <= settle;
        settle:    state <= idle;
        default:   state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (startFill) begin
      blockBase <= cpuAddr[addrW-1:offW+1];       // latched once per refill
    end
  end

  // cache side
  assign fillAddr   = {blockBase, wordCnt, 1'b0};
  assign fillData   = memRdData;
  assign fillDataWe = (state == waitData) & memRdValid;
  assign fillMetaWe = (state == writeMeta);

  // memory side
  assign memRd     = (state == request);
  assign memWr     = writeHit;
  assign memWrData = cpuWrData;
  assign memAddr   = (state == idle) ? cpuAddr[addrW-1:1] : fillAddr[addrW-1:1];

endmodule

`default_nettype wire

//--- project.f
common/cachePkg.sv
dataCache/dataArray.sv
dataCache/metaArray.sv
dataCache/dataCache.sv
hdl/missHandler.sv
hdl/mainMemory.sv
hdl/cacheTop.sv
bench/clockGen.sv
bench/cacheTb.sv
